// ==== list.f ====
+incdir+test
verilog/spike_pkg.sv
verilog/spike_channels.sv
verilog/gen_state_mem.sv
verilog/time_unit_timer.sv
verilog/spike_generator_array.sv
verilog/spike_out_fifo.sv
verilog/spike_source_top.sv
test/spike_source_tb.sv

// ==== Bender.yml ====
package:
  name: spike_source

sources:
  - target: rtl
    files:
      - verilog/spike_pkg.sv
      - verilog/spike_channels.sv
      - verilog/gen_state_mem.sv
      - verilog/time_unit_timer.sv
      - verilog/spike_generator_array.sv
      - verilog/spike_out_fifo.sv
      - verilog/spike_source_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/spike_source_tb.sv

// ==== test/spike_model.svh ====
`ifndef SPIKE_MODEL_SVH
`define SPIKE_MODEL_SVH

////////////////////////////////
// generator table model

// one entry per generator, as last programmed or updated
tick_t   model_tick   [n_gens];
period_t model_period [n_gens];
tag_t    model_tag    [n_gens];

// tags in the order the output port has to deliver them
tag_t    expected_q [$];

function automatic void model_init();
  for (int i = 0; i < n_gens; i++) begin
    model_tick[i]   = '0;
    model_period[i] = '0;
    model_tag[i]    = '0;
  end
  expected_q.delete();
endfunction

// accepted programming request
function automatic void model_write(input gen_idx_t idx, input tick_t ticks,
                                    input period_t period, input tag_t tag);
  model_tick[idx]   = ticks;
  model_period[idx] = period;
  model_tag[idx]    = tag;
endfunction

// one time unit, generators in index order
// only enabled entries below the used count move, the rest keep their tick
function automatic void model_scan(input gen_count_t used, input gen_mask_t en);
  for (int i = 0; i < n_gens; i++) begin
    if ((i < int'(used)) && en[i]) begin
      if (model_tick[i] < model_period[i]) begin
        model_tick[i] = model_tick[i] + tick_t'(1);
      end else begin
        // fired, count restarts at one
        model_tick[i] = tick_t'(1);
        expected_q.push_back(model_tag[i]);
      end
    end
  end
endfunction

`endif

// ==== test/spike_source_tb.sv ====
`timescale 1ns/10ps

module spike_source_tb;

  import spike_pkg::*;

  `include "spike_model.svh"

  // cycles per time unit, long enough for a full scan with stalls
  localparam int unit_clks      = 256;
  // units consumed by the five tests together
  localparam int units_run      = 54;
  localparam int timeout_cycles = units_run * unit_clks + 2000;
  // output held off this long at the start of each unit under back-pressure
  localparam int stall_clks     = 40;

  logic       clk;
  logic       reset;
  unit_len_t  clks_per_unit;
  gen_count_t gens_used;
  gen_mask_t  gens_en;
  logic       prog_valid;
  logic       prog_ready;
  gen_idx_t   prog_gen_idx;
  tick_t      prog_ticks;
  period_t    prog_period;
  tag_t       prog_tag;
  logic       spike_valid;
  logic       spike_ready;
  tag_t       spike_tag;

  // random output stalls when set
  logic        bp_mode;
  // rising edges since reset fell
  int unsigned cyc;
  int unsigned watchdog = 0;

  // bookkeeping
  int   error_count      = 0;
  int   test_fails       = 0;
  int   spikes_seen      = 0;
  int   prog_requests    = 0;
  int   prog_grants      = 0;
  int   test_err_start   = 0;
  int   test_spike_start = 0;
  tag_t exp_tag;

  spike_source_top u_spike_source_top (
    .clk           (clk),
    .reset         (reset),
    .clks_per_unit (clks_per_unit),
    .gens_used     (gens_used),
    .gens_en       (gens_en),
    .prog_valid    (prog_valid),
    .prog_ready    (prog_ready),
    .prog_gen_idx  (prog_gen_idx),
    .prog_ticks    (prog_ticks),
    .prog_period   (prog_period),
    .prog_tag      (prog_tag),
    .spike_valid   (spike_valid),
    .spike_ready   (spike_ready),
    .spike_tag     (spike_tag)
  );

  ////////////////////////////////
  // clock, edge count, watchdog

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  always @(posedge clk) begin
    watchdog = watchdog + 1;
    if (watchdog >= timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // output ready, driven on the falling edge
  // under back-pressure the port stays low at the start of each unit
  // so the FIFO fills and the scan has to wait in its read step
  always @(negedge clk) begin
    if (bp_mode) begin
      if ((cyc % unit_clks) < stall_clks) begin
        spike_ready = 1'b0;
      end else begin
        spike_ready = 1'($urandom_range(1, 0));
      end
    end else begin
      spike_ready = 1'b1;
    end
  end

  ////////////////////////////////
  // monitor and model update

  // cyc still holds its old value here
  // the array takes the unit pulse on the edge where that value is a multiple of the unit
  always @(posedge clk) begin
    if (!reset) begin
      if (spike_valid && spike_ready) begin
        spikes_seen++;
        if (expected_q.size() == 0) begin
          $display("spike with tag 0x%03h arrived while no spike was expected", spike_tag);
          error_count++;
        end else begin
          exp_tag = expected_q.pop_front();
          if (spike_tag !== exp_tag) begin
            $display("[ERROR] spike_tag expected 0x%03h received 0x%03h", exp_tag, spike_tag);
            error_count++;
          end
        end
      end
      if (prog_valid && prog_ready) begin
        prog_grants++;
        model_write(prog_gen_idx, prog_ticks, prog_period, prog_tag);
      end
      if ((cyc != 0) && ((cyc % unit_clks) == 0)) begin
        model_scan(gens_used, gens_en);
      end
    end
  end

  ////////////////////////////////
  // stimulus helpers

  // midpoint of a unit, no scan running
  task automatic settle_mid();
    while ((cyc % unit_clks) != (unit_clks / 2)) begin
      @(negedge clk);
    end
  endtask

  task automatic run_units(input int n);
    repeat (n) begin
      do begin
        @(negedge clk);
      end while ((cyc % unit_clks) != (unit_clks / 2));
    end
  endtask

  // valid stays up until the edge that takes the word
  task automatic program_gen(input gen_idx_t idx, input tick_t ticks,
                             input period_t period, input tag_t tag);
    int waited;
    waited        = 0;
    prog_valid    = 1'b1;
    prog_gen_idx  = idx;
    prog_ticks    = ticks;
    prog_period   = period;
    prog_tag      = tag;
    prog_requests++;
    @(posedge clk);
    while (!prog_ready && (waited < 64)) begin
      @(posedge clk);
      waited++;
    end
    if (!prog_ready) begin
      $display("programming request for generator %0d was never accepted", idx);
      error_count++;
    end
    @(negedge clk);
    prog_valid = 1'b0;
  endtask

  task automatic begin_test();
    test_err_start   = error_count;
    test_spike_start = spikes_seen;
    settle_mid();
  endtask

  task automatic end_test(input int num, input string name);
    int waited;
    int errs;
    waited = 0;
    while ((expected_q.size() != 0) && (waited < 512)) begin
      @(negedge clk);
      waited++;
    end
    if (expected_q.size() != 0) begin
      $display("%0d expected spikes never arrived in test %0d", expected_q.size(), num);
      error_count++;
      expected_q.delete();
    end
    errs = error_count - test_err_start;
    if (errs != 0) begin
      test_fails++;
    end
    $display("test %0d %s: %0d spikes, %0d errors, %s", num, name,
             spikes_seen - test_spike_start, errs, (errs == 0) ? "ok" : "failed");
  endtask

  ////////////////////////////////
  // tests

  task automatic periodic_test();
    begin_test();
    for (int i = 0; i < n_gens; i++) begin
      program_gen(gen_idx_t'(i), '0, period_t'($urandom_range(6, 1)), tag_t'($urandom));
    end
    gens_used = gen_count_t'(n_gens);
    gens_en   = '1;
    run_units(12);
    end_test(1, "periodic firing");
  endtask

  task automatic phase_test();
    int p;
    begin_test();
    p = $urandom_range(6, 3);
    // same period, phase set by the start tick
    for (int i = 0; i < n_gens; i++) begin
      program_gen(gen_idx_t'(i), tick_t'(i % p), period_t'(p), tag_t'($urandom));
    end
    run_units(10);
    end_test(2, "phase from initial ticks");
  endtask

  task automatic mask_test();
    begin_test();
    repeat (6) begin
      gens_en   = gen_mask_t'($urandom);
      gens_used = gen_count_t'($urandom_range(n_gens, 0));
      run_units(2);
    end
    end_test(3, "enable mask and gens_used");
  endtask

  task automatic backpressure_test();
    begin_test();
    // every generator fires on every unit
    for (int i = 0; i < n_gens; i++) begin
      program_gen(gen_idx_t'(i), tick_t'(1), period_t'(1), tag_t'($urandom));
    end
    gens_used = gen_count_t'(n_gens);
    gens_en   = '1;
    bp_mode   = 1'b1;
    run_units(8);
    bp_mode   = 1'b0;
    end_test(4, "back-pressure");
  endtask

  task automatic reprogram_test();
    begin_test();
    repeat (6) begin
      program_gen(gen_idx_t'($urandom_range(n_gens - 1, 0)), tick_t'($urandom_range(3, 0)),
                  period_t'($urandom_range(6, 1)), tag_t'($urandom));
      run_units(2);
    end
    if (prog_grants != prog_requests) begin
      $display("only %0d of %0d programming requests were accepted",
               prog_grants, prog_requests);
      error_count++;
    end
    end_test(5, "reprogramming");
  endtask

  ////////////////////////////////
  // main sequence

  initial begin
    void'($urandom(32'hda471fa1));
    reset         = 1'b1;
    clks_per_unit = unit_len_t'(unit_clks);
    gens_used     = '0;
    gens_en       = '0;
    prog_valid    = 1'b0;
    prog_gen_idx  = '0;
    prog_ticks    = '0;
    prog_period   = '0;
    prog_tag      = '0;
    spike_ready   = 1'b1;
    bp_mode       = 1'b0;
    model_init();
    repeat (5) @(negedge clk);
    reset = 1'b0;

    periodic_test();
    phase_test();
    mask_test();
    backpressure_test();
    reprogram_test();

    $display("tests run: 5, failed: %0d, errors: %0d, spikes checked: %0d",
             test_fails, error_count, spikes_seen);
    if ((error_count == 0) && (test_fails == 0)) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== verilog/spike_source_top.sv ====
`timescale 1ns/10ps

// periodic spike source
// timer, generator array and output FIFO
module spike_source_top (
  input  logic                  clk,
  input  logic                  reset,
  input  spike_pkg::unit_len_t  clks_per_unit,
  input  spike_pkg::gen_count_t gens_used,
  input  spike_pkg::gen_mask_t  gens_en,
  input  logic                  prog_valid,
  output logic                  prog_ready,
  input  spike_pkg::gen_idx_t   prog_gen_idx,
  input  spike_pkg::tick_t      prog_ticks,
  input  spike_pkg::period_t    prog_period,
  input  spike_pkg::tag_t       prog_tag,
  output logic                  spike_valid,
  input  logic                  spike_ready,
  output spike_pkg::tag_t       spike_tag
);

  import spike_pkg::*;

  logic unit_pulse;

  // array to FIFO
  logic spk_valid;
  logic spk_ready;
  tag_t spk_tag;

  ////////////////////////////////
  // programming port

  program_channel prog_if ();

  assign prog_if.valid   = prog_valid;
  assign prog_if.gen_idx = prog_gen_idx;
  assign prog_if.ticks   = prog_ticks;
  assign prog_if.period  = prog_period;
  assign prog_if.tag     = prog_tag;
  assign prog_ready      = prog_if.ready;

  ////////////////////////////////
  // blocks

  time_unit_timer u_time_unit_timer (
    .clk           (clk),
    .reset         (reset),
    .clks_per_unit (clks_per_unit),
    .unit_pulse    (unit_pulse)
  );

  spike_generator_array u_spike_generator_array (
    .clk        (clk),
    .reset      (reset),
    .unit_pulse (unit_pulse),
    .gens_used  (gens_used),
    .gens_en    (gens_en),
    .prog       (prog_if.sink),
    .spk_valid  (spk_valid),
    .spk_ready  (spk_ready),
    .spk_tag    (spk_tag)
  );

  spike_out_fifo u_spike_out_fifo (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (spk_valid),
    .in_ready  (spk_ready),
    .in_tag    (spk_tag),
    .out_valid (spike_valid),
    .out_ready (spike_ready),
    .out_tag   (spike_tag)
  );

endmodule

// ==== verilog/spike_out_fifo.sv ====
`timescale 1ns/10ps

// spike tag FIFO between the generator array and the output port
// valid/ready on both sides
module spike_out_fifo (
  input  logic            clk,
  input  logic            reset,
  input  logic            in_valid,
  output logic            in_ready,
  input  spike_pkg::tag_t in_tag,
  output logic            out_valid,
  input  logic            out_ready,
  output spike_pkg::tag_t out_tag
);

  import spike_pkg::*;

  // storage
  tag_t        fifo_mem [0:fifo_depth-1];

  // pointers and occupancy
  fifo_ptr_t   wr_ptr;
  fifo_ptr_t   rd_ptr;
  fifo_count_t count;

  logic        push;
  logic        pop;

  ////////////////////////////////
  // handshake

  assign in_ready  = (count != fifo_count_t'(fifo_depth));
  assign out_valid = (count != '0);
  assign out_tag   = fifo_mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  ////////////////////////////////
  // storage write

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= in_tag;
    end
  end

  ////////////////////////////////
  // pointers

  // depth is a power of two so the pointers wrap on overflow
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + fifo_ptr_t'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + fifo_ptr_t'(1);
      end
      // push and pop together leave the count alone
      unique case ({push, pop})
        2'b10:   count <= count + fifo_count_t'(1);
        2'b01:   count <= count - fifo_count_t'(1);
        default: count <= count;
      endcase
    end
  end

  // the array checks for room before it reads, so a full FIFO is never pushed
  a_no_push_full: assert property (@(posedge clk) disable iff (reset)
    in_valid |-> in_ready);

endmodule

// ==== verilog/spike_generator_array.sv ====
`timescale 1ns/10ps

// array of periodic spike generators
// per generator state lives in a block memory
// each unit pulse starts one scan over the generators in use
// an enabled generator takes three cycles, read then wait then write
// a disabled one is skipped in a single cycle
module spike_generator_array (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  unit_pulse,
  input  spike_pkg::gen_count_t gens_used,
  input  spike_pkg::gen_mask_t  gens_en,
  program_channel.sink          prog,
  output logic                  spk_valid,
  input  logic                  spk_ready,
  output spike_pkg::tag_t       spk_tag
);

  import spike_pkg::*;

  // scan control
  scan_state_t state;
  scan_state_t next_state;
  gen_idx_t    idx;
  gen_idx_t    next_idx;
  gen_count_t  idx_p1;
  logic        last_gen;
  logic        cur_en;

  // programming
  logic        prog_accept;
  mem_word_t   prog_word;

  // memory ports
  logic        mem_wr_en;
  gen_idx_t    mem_wr_addr;
  mem_word_t   mem_wr_data;
  logic        mem_rd_en;
  mem_word_t   mem_rd_data;

  // writeback datapath
  tick_t       rd_tick;
  tick_t       wr_tick;
  period_t     rd_period;
  tag_t        rd_tag;
  mem_word_t   back_word;
  logic        fire;

  gen_state_mem u_gen_state_mem (
    .clk     (clk),
    .wr_en   (mem_wr_en),
    .wr_addr (mem_wr_addr),
    .wr_data (mem_wr_data),
    .rd_en   (mem_rd_en),
    .rd_addr (idx),
    .rd_data (mem_rd_data)
  );

  ////////////////////////////////
  // scan FSM

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= scan_idle;
      idx   <= '0;
    end else begin
      state <= next_state;
      idx   <= next_idx;
    end
  end

  // one adder shared by the skip and writeback steps
  assign idx_p1   = gen_count_t'(idx) + gen_count_t'(1);
  assign last_gen = (idx_p1 >= gens_used);
  assign cur_en   = gens_en[idx];

  always_comb begin
    next_state = state;
    next_idx   = idx;
    unique case (state)
      scan_idle: begin
        // nothing to scan when no generator is in use
        if (unit_pulse && (gens_used != '0)) begin
          next_state = scan_read;
          next_idx   = '0;
        end
      end
      scan_read: begin
        if (!cur_en) begin
          // skip a disabled generator
          next_state = last_gen ? scan_idle : scan_read;
          next_idx   = gen_idx_t'(idx_p1);
        end else if (spk_ready) begin
          // the FIFO has room, so the spike of this step can be taken
          next_state = scan_wait;
        end
      end
      scan_wait: begin
        // word moves into the memory output register
        next_state = scan_write;
      end
      scan_write: begin
        next_state = last_gen ? scan_idle : scan_read;
        next_idx   = gen_idx_t'(idx_p1);
      end
      default: begin
        next_state = scan_idle;
      end
    endcase
  end

  ////////////////////////////////
  // programming

  // writes only go in between scans
  assign prog.ready  = prog.valid && (state == scan_idle);
  assign prog_accept = prog.valid && prog.ready;

  always_comb begin
    prog_word = '0;
    prog_word[tick_lsb +: tick_w]     = prog.ticks;
    prog_word[period_lsb +: period_w] = prog.period;
    prog_word[tag_lsb +: tag_w]       = prog.tag;
  end

  ////////////////////////////////
  // tick update

  // memory output is valid in the write cycle
  always_comb begin
    rd_tick   = mem_rd_data[tick_lsb +: tick_w];
    rd_period = mem_rd_data[period_lsb +: period_w];
    rd_tag    = mem_rd_data[tag_lsb +: tag_w];
  end

  // tick counts units since the last spike
  // it restarts at one when the generator fires
  always_comb begin
    if (rd_tick < rd_period) begin
      wr_tick = rd_tick + tick_t'(1);
      fire    = 1'b0;
    end else begin
      wr_tick = tick_t'(1);
      fire    = 1'b1;
    end
  end

  // period and tag go back unchanged
  always_comb begin
    back_word = '0;
    back_word[tick_lsb +: tick_w]     = wr_tick;
    back_word[period_lsb +: period_w] = rd_period;
    back_word[tag_lsb +: tag_w]       = rd_tag;
  end

  ////////////////////////////////
  // memory port control

  // writeback in the write state, program word while idle
  always_comb begin
    mem_wr_en   = 1'b0;
    mem_wr_addr = idx;
    mem_wr_data = back_word;
    if (state == scan_write) begin
      mem_wr_en = 1'b1;
    end else if (prog_accept) begin
      mem_wr_en   = 1'b1;
      mem_wr_addr = prog.gen_idx;
      mem_wr_data = prog_word;
    end
  end

  // read once the FIFO can take a possible spike
  assign mem_rd_en = (state == scan_read) && cur_en && spk_ready;

  ////////////////////////////////
  // spike output

  assign spk_valid = (state == scan_write) && fire;
  assign spk_tag   = rd_tag;

  // the unit length must leave room for a full scan
  a_pulse_in_idle: assert property (@(posedge clk) disable iff (reset)
    unit_pulse |-> (state == scan_idle));

  // room seen at the read is still there at the write
  a_emit_ready: assert property (@(posedge clk) disable iff (reset)
    spk_valid |-> spk_ready);

  a_gens_used_range: assert property (@(posedge clk) disable iff (reset)
    gens_used <= gen_count_t'(n_gens));

endmodule

// ==== verilog/time_unit_timer.sv ====
`timescale 1ns/10ps

// time unit timer
// one single cycle pulse every clks_per_unit clocks
module time_unit_timer (
  input  logic                 clk,
  input  logic                 reset,
  input  spike_pkg::unit_len_t clks_per_unit,
  output logic                 unit_pulse
);

  import spike_pkg::*;

  unit_len_t count;
  // low until the first load after reset
  logic      running;
  logic      reload;

  // load on the first cycle after reset and each time the count expires
  assign reload = !running || (count == '0);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count   <= '0;
      running <= 1'b0;
    end else if (reload) begin
      running <= 1'b1;
      // new unit length takes effect here
      count   <= clks_per_unit - unit_len_t'(1);
    end else begin
      count   <= count - unit_len_t'(1);
    end
  end

  // pulse while the loaded count sits at zero
  assign unit_pulse = running && (count == '0);

  // a single cycle unit would pulse on every clock
  a_unit_len_min: assert property (@(posedge clk) disable iff (reset)
    reload |-> (clks_per_unit >= unit_len_t'(2)));

endmodule

// ==== verilog/gen_state_mem.sv ====
`timescale 1ns/10ps

// simple dual port block memory for the generator words
// one write port and one read port
// read data comes out two cycles after rd_en
module gen_state_mem (
  input  logic                 clk,
  input  logic                 wr_en,
  input  spike_pkg::gen_idx_t  wr_addr,
  input  spike_pkg::mem_word_t wr_data,
  input  logic                 rd_en,
  input  spike_pkg::gen_idx_t  rd_addr,
  output spike_pkg::mem_word_t rd_data
);

  import spike_pkg::*;

  // one word per generator
  mem_word_t mem [0:n_gens-1];

  // first stage after the array
  mem_word_t rd_q;

  ////////////////////////////////
  // write port

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  ////////////////////////////////
  // read port

  // read register, loaded only on a read
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_q <= mem[rd_addr];
    end
  end

  // output register
  // second cycle of latency
  always_ff @(posedge clk) begin
    rd_data <= rd_q;
  end

  // the scan never reads the word it is writing back in the same cycle
  a_no_rw_collision: assert property (@(posedge clk)
    (wr_en && rd_en) |-> (wr_addr != rd_addr));

endmodule

// ==== verilog/spike_channels.sv ====
`timescale 1ns/10ps

////////////////////////////////
// generator programming channel

// one request writes a complete generator word
// the source holds the data steady while valid is high
// a word is taken on a cycle where valid and ready are both high
interface program_channel;

  import spike_pkg::*;

  // handshake
  logic     valid;
  logic     ready;

  // target generator
  gen_idx_t gen_idx;

  // initial tick count, sets the firing phase
  tick_t    ticks;

  // firing interval in time units
  period_t  period;

  // destination carried by every spike of this generator
  tag_t     tag;

  // side that issues write requests
  modport source (
    output valid,
    output gen_idx,
    output ticks,
    output period,
    output tag,
    input  ready
  );

  // side that owns the generator table
  modport sink (
    input  valid,
    input  gen_idx,
    input  ticks,
    input  period,
    input  tag,
    output ready
  );

endinterface

// ==== verilog/spike_pkg.sv ====
package spike_pkg;

  ////////////////////////////////
  // sizes

  // generator table
  localparam int n_gens     = 16;
  localparam int gen_idx_w  = $clog2(n_gens);

  // field widths of one generator word
  localparam int tick_w     = 16;
  localparam int period_w   = 16;
  localparam int tag_w      = 11;
  localparam int unit_len_w = 16;
  localparam int mem_w      = tick_w + period_w + tag_w;

  // word layout, tick in the top bits and tag at the bottom
  localparam int tag_lsb    = 0;
  localparam int period_lsb = tag_lsb + tag_w;
  localparam int tick_lsb   = period_lsb + period_w;

  // output buffering
  localparam int fifo_depth = 8;
  localparam int fifo_ptr_w = $clog2(fifo_depth);

  ////////////////////////////////
  // types

  typedef logic [gen_idx_w-1:0]  gen_idx_t;
  // one extra bit so that the full count fits
  typedef logic [gen_idx_w:0]    gen_count_t;
  typedef logic [n_gens-1:0]     gen_mask_t;
  typedef logic [tick_w-1:0]     tick_t;
  typedef logic [period_w-1:0]   period_t;
  typedef logic [tag_w-1:0]      tag_t;
  typedef logic [unit_len_w-1:0] unit_len_t;
  typedef logic [mem_w-1:0]      mem_word_t;
  typedef logic [fifo_ptr_w-1:0] fifo_ptr_t;
  typedef logic [fifo_ptr_w:0]   fifo_count_t;

  // scan FSM of the generator array
  typedef enum logic [1:0] {
    scan_idle,
    scan_read,
    scan_wait,
    scan_write
  } scan_state_t;

endpackage
